/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_riscv_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;     // data or address
    typedef logic [4:0]  reg_addr_t; // x0..x31
    typedef logic [31:0] inst_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_TYPE_I = 7'b0010011; // addi group
    localparam logic [6:0] OPC_TYPE_R = 7'b0110011; // add / sub
    localparam logic [6:0] OPC_TYPE_B = 7'b1100011; // branches
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3, inst[14:12]
    localparam logic [2:0] F3_ADDI    = 3'b000;
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7, inst[31:25]; zero means add
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam word_t RESET_PC = 32'h0000_0000;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

/* design/ctrl.sv */
`timescale 1ns/1ps

module ctrl import core_pkg::*; (
    // from ex
    input  logic  jump_en_i,
    input  word_t jump_addr_i,

    // to pc_reg
    output logic  jump_o,
    output word_t jump_addr_o,

    // to if_id and id_ex
    output logic  flush_o
);

    // taken jump kills the two younger instructions
    always_comb begin
        jump_o      = jump_en_i;
        flush_o     = jump_en_i;
        jump_addr_o = jump_en_i ? jump_addr_i : RESET_PC; // quiet when not taken
    end

endmodule

/* design/ex.sv */
`timescale 1ns/1ps

module ex import core_pkg::*; (
    // from id_ex
    input  inst_t     inst_i,
    input  word_t     inst_addr_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  reg_addr_t rd_addr_i,
    input  logic      reg_wen_i,

    // write-back
    output word_t     rd_wdata_o,
    output reg_addr_t rd_waddr_o,
    output logic      reg_wen_o,

    // to ctrl
    output word_t     jump_addr_o,
    output logic      jump_en_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_b;
    logic       op_equal;
    logic       wr_op;     // instruction kind produces a result

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign op_equal = (op1_i == op2_i);

    always_comb begin
        rd_wdata_o  = '0;
        wr_op       = 1'b0;
        jump_addr_o = '0;
        jump_en_o   = 1'b0;
        case (opcode)
            OPC_TYPE_I: begin
                rd_wdata_o = op1_i + op2_i; // addi
                wr_op      = 1'b1;
            end
            OPC_TYPE_R: begin
                if (funct7 == F7_SUB) begin
                    rd_wdata_o = op1_i - op2_i; // rs1 - rs2
                end else begin
                    rd_wdata_o = op1_i + op2_i;
                end
                wr_op = 1'b1;
            end
            OPC_TYPE_B: begin
                jump_addr_o = inst_addr_i + imm_b;
                if (funct3 == F3_BEQ) begin
                    jump_en_o = op_equal;
                end else if (funct3 == F3_BNE) begin
                    jump_en_o = !op_equal;
                end
            end
            OPC_JAL: begin
                rd_wdata_o  = inst_addr_i + 32'd4; // link address
                wr_op       = 1'b1;
                jump_addr_o = inst_addr_i + op1_i;
                jump_en_o   = 1'b1;
            end
            OPC_LUI: begin
                rd_wdata_o = op1_i;
                wr_op      = 1'b1;
            end
            default: ;
        endcase
    end

    assign rd_waddr_o = rd_addr_i;
    assign reg_wen_o  = reg_wen_i && wr_op;

endmodule

/* design/id.sv */
`timescale 1ns/1ps

module id import core_pkg::*; (
    // from if_id
    input  inst_t     inst_i,
    input  word_t     inst_addr_i,

    // register file read ports
    input  word_t     rs1_rdata_i,
    input  word_t     rs2_rdata_i,
    output reg_addr_t rs1_raddr_o,
    output reg_addr_t rs2_raddr_o,

    // to id_ex
    output word_t     op1_o,
    output word_t     op2_o,
    output reg_addr_t rd_addr_o,
    output logic      reg_wen_o,
    output inst_t     inst_o,
    output word_t     inst_addr_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    word_t imm_i;
    word_t imm_j;
    word_t imm_u;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    assign rs1_raddr_o = rs1;
    assign rs2_raddr_o = rs2;
    assign rd_addr_o   = rd;
    assign inst_o      = inst_i;
    assign inst_addr_o = inst_addr_i;

    always_comb begin
        op1_o     = '0;
        op2_o     = '0;
        reg_wen_o = 1'b0; // anything unknown writes nothing
        case (opcode)
            OPC_TYPE_I: begin
                if (funct3 == F3_ADDI) begin
                    op1_o     = rs1_rdata_i;
                    op2_o     = imm_i;
                    reg_wen_o = 1'b1;
                end
            end
            OPC_TYPE_R: begin
                if (funct3 == F3_ADD_SUB && (funct7 == 7'b0 || funct7 == F7_SUB)) begin
                    op1_o     = rs1_rdata_i;
                    op2_o     = rs2_rdata_i;
                    reg_wen_o = 1'b1;
                end
            end
            OPC_TYPE_B: begin
                // branch offset is rebuilt in ex from the instruction
                op1_o = rs1_rdata_i;
                op2_o = rs2_rdata_i;
            end
            OPC_JAL: begin
                op1_o     = imm_j;
                reg_wen_o = 1'b1;
            end
            OPC_LUI: begin
                op1_o     = imm_u;
                reg_wen_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* design/id_ex.sv */
`timescale 1ns/1ps

module id_ex import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      flush_i,

    // from id
    input  inst_t     inst_i,
    input  word_t     inst_addr_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  reg_addr_t rd_addr_i,
    input  logic      reg_wen_i,

    // to ex
    output inst_t     inst_o,
    output word_t     inst_addr_o,
    output word_t     op1_o,
    output word_t     op2_o,
    output reg_addr_t rd_addr_o,
    output logic      reg_wen_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            inst_o      <= NOP_INST;
            inst_addr_o <= RESET_PC;
            op1_o       <= '0;
            op2_o       <= '0;
            rd_addr_o   <= '0;
            reg_wen_o   <= 1'b0; // squashed slot never writes
        end else begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
            op1_o       <= op1_i;
            op2_o       <= op2_i;
            rd_addr_o   <= rd_addr_i;
            reg_wen_o   <= reg_wen_i;
        end
    end

endmodule

/* design/if_id.sv */
`timescale 1ns/1ps

module if_id import core_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  flush_i,

    // from fetch
    input  inst_t inst_i,
    input  word_t inst_addr_i,

    // to id
    output inst_t inst_o,
    output word_t inst_addr_o
);

    inst_t inst_q;
    word_t inst_addr_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            inst_q      <= NOP_INST; // bubble
            inst_addr_q <= RESET_PC;
        end else begin
            inst_q      <= inst_i;
            inst_addr_q <= inst_addr_i;
        end
    end

    assign inst_o      = inst_q;
    assign inst_addr_o = inst_addr_q;

endmodule

/* design/pc_reg.sv */
`timescale 1ns/1ps

module pc_reg import core_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  jump_i,      // from ctrl
    input  word_t jump_addr_i,
    output word_t pc_o         // fetch address
);

    word_t pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (jump_i) begin
            pc_q <= jump_addr_i; // redirect wins over sequential step
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

/* design/regs.sv */
`timescale 1ns/1ps

module regs import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // write port, from ex
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,

    // read ports, to id
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, same-cycle write bypassed
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (we_i && waddr_i == raddr1_i) begin
            rdata1_o = wdata_i;
        end else begin
            rdata1_o = regs_q[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (we_i && waddr_i == raddr2_i) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = regs_q[raddr2_i];
        end
    end

endmodule

/* design/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // instruction memory, answers in the same cycle
    input  inst_t     inst_i,
    output word_t     inst_addr_o,

    // observed write-back
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t     pc;

    inst_t     if_id_inst;
    word_t     if_id_inst_addr;

    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;

    inst_t     id_inst;
    word_t     id_inst_addr;
    word_t     id_op1;
    word_t     id_op2;
    reg_addr_t id_rd_addr;
    logic      id_reg_wen;

    inst_t     ex_inst;
    word_t     ex_inst_addr;
    word_t     ex_op1;
    word_t     ex_op2;
    reg_addr_t ex_rd_addr;
    logic      ex_reg_wen;

    word_t     rd_wdata;
    reg_addr_t rd_waddr;
    logic      rd_wen;
    word_t     ex_jump_addr;
    logic      ex_jump_en;

    logic      jump;
    word_t     jump_addr;
    logic      flush;

    pc_reg u_pc_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .jump_i     (jump),
        .jump_addr_i(jump_addr),
        .pc_o       (pc)
    );

    assign inst_addr_o = pc;

    if_id u_if_id (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .inst_i     (inst_i),
        .inst_addr_i(pc),
        .inst_o     (if_id_inst),
        .inst_addr_o(if_id_inst_addr)
    );

    id u_id (
        .inst_i     (if_id_inst),
        .inst_addr_i(if_id_inst_addr),
        .rs1_rdata_i(rs1_rdata),
        .rs2_rdata_i(rs2_rdata),
        .rs1_raddr_o(rs1_raddr),
        .rs2_raddr_o(rs2_raddr),
        .op1_o      (id_op1),
        .op2_o      (id_op2),
        .rd_addr_o  (id_rd_addr),
        .reg_wen_o  (id_reg_wen),
        .inst_o     (id_inst),
        .inst_addr_o(id_inst_addr)
    );

    regs u_regs (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (rd_wen),
        .waddr_i (rd_waddr),
        .wdata_i (rd_wdata),
        .raddr1_i(rs1_raddr),
        .raddr2_i(rs2_raddr),
        .rdata1_o(rs1_rdata),
        .rdata2_o(rs2_rdata)
    );

    id_ex u_id_ex (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .inst_i     (id_inst),
        .inst_addr_i(id_inst_addr),
        .op1_i      (id_op1),
        .op2_i      (id_op2),
        .rd_addr_i  (id_rd_addr),
        .reg_wen_i  (id_reg_wen),
        .inst_o     (ex_inst),
        .inst_addr_o(ex_inst_addr),
        .op1_o      (ex_op1),
        .op2_o      (ex_op2),
        .rd_addr_o  (ex_rd_addr),
        .reg_wen_o  (ex_reg_wen)
    );

    ex u_ex (
        .inst_i     (ex_inst),
        .inst_addr_i(ex_inst_addr),
        .op1_i      (ex_op1),
        .op2_i      (ex_op2),
        .rd_addr_i  (ex_rd_addr),
        .reg_wen_i  (ex_reg_wen),
        .rd_wdata_o (rd_wdata),
        .rd_waddr_o (rd_waddr),
        .reg_wen_o  (rd_wen),
        .jump_addr_o(ex_jump_addr),
        .jump_en_o  (ex_jump_en)
    );

    ctrl u_ctrl (
        .jump_en_i  (ex_jump_en),
        .jump_addr_i(ex_jump_addr),
        .jump_o     (jump),
        .jump_addr_o(jump_addr),
        .flush_o    (flush)
    );

    // write-back port brought out for observation
    assign wb_en_o   = rd_wen;
    assign wb_addr_o = rd_waddr;
    assign wb_data_o = rd_wdata;

endmodule

/* testbench/tb_riscv_core.sv */
`timescale 1ns/1ps

module tb_riscv_core import core_pkg::*; ();

    typedef enum logic [2:0] {K_ADDI, K_ADD, K_SUB, K_LUI, K_BEQ, K_BNE, K_JAL} kind_t;

    logic      clk_i = 1'b0; // low from the start so time 0 has no falling edge
    logic      reset_i;
    inst_t     inst_i;
    word_t     inst_addr_o;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    // program image plus the fields it was encoded from
    inst_t     mem [64];
    kind_t     kind_m [64];
    reg_addr_t rd_m [64];
    reg_addr_t rs1_m [64];
    reg_addr_t rs2_m [64];
    word_t     imm_m [64];   // sign-extended immediate or byte offset

    word_t     model_rf [32];
    word_t     model_pc;
    integer    seed;
    int        cycles;
    int        matched;

    riscv_core dut0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .inst_i     (inst_i),
        .inst_addr_o(inst_addr_o),
        .wb_en_o    (wb_en_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic build_program();
        logic [5:0]  idx;
        logic [11:0] imm12;
        logic [19:0] imm20;
        word_t       off;
        int          pick;
        int          target;
        for (int i = 0; i < 64; i++) begin
            idx        = 6'(i);
            pick       = (i % 4 == 0) ? rand_below(4) : rand_below(8);
            rd_m[idx]  = 5'(rand_below(8));
            rs1_m[idx] = 5'(rand_below(8));
            rs2_m[idx] = (rand_below(4) == 0) ? rs1_m[idx] : 5'(rand_below(8));
            imm12      = 12'(rand_below(4096));
            imm20      = 20'(rand_below(1 << 20));
            if (i % 4 == 0 || pick == 6) begin
                rd_m[idx] = 5'(1 + rand_below(7)); // guaranteed visible write
            end
            case (pick)
                1, 2: begin
                    kind_m[idx] = (pick == 1) ? K_ADD : K_SUB;
                    mem[idx] = {(pick == 2) ? F7_SUB : 7'b0, rs2_m[idx], rs1_m[idx],
                                F3_ADD_SUB, rd_m[idx], OPC_TYPE_R};
                end
                3: begin
                    kind_m[idx] = K_LUI;
                    imm_m[idx]  = {imm20, 12'b0};
                    mem[idx]    = {imm20, rd_m[idx], OPC_LUI};
                end
                4, 5: begin
                    kind_m[idx] = (pick == 4) ? K_BEQ : K_BNE;
                    off         = word_t'(4 * (1 + rand_below(3))); // forward 1..3 words
                    imm_m[idx]  = off;
                    mem[idx] = {off[12], off[10:5], rs2_m[idx], rs1_m[idx],
                                (pick == 4) ? F3_BEQ : F3_BNE, off[4:1], off[11], OPC_TYPE_B};
                end
                6: begin
                    kind_m[idx] = K_JAL;
                    target      = rand_below(64);
                    if (target == i) begin
                        target = (i + 1) % 64; // no jump onto itself
                    end
                    off        = word_t'(4 * (target - i));
                    imm_m[idx] = off;
                    mem[idx]   = {off[20], off[10:1], off[11], off[19:12], rd_m[idx], OPC_JAL};
                end
                default: begin
                    kind_m[idx] = K_ADDI;
                    imm_m[idx]  = {{20{imm12[11]}}, imm12};
                    mem[idx]    = {imm12, rs1_m[idx], F3_ADDI, rd_m[idx], OPC_TYPE_I};
                end
            endcase
        end
    endtask

    // ISA-level run up to the next write of a nonzero register
    task automatic next_model_write(output reg_addr_t addr, output word_t data);
        logic [5:0] slot;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      next_pc;
        bit         found;
        int         steps;
        found = 1'b0;
        addr  = '0;
        data  = '0;
        for (steps = 0; steps < 256 && !found; steps++) begin
            slot    = model_pc[7:2]; // same wrap as the memory
            a       = model_rf[rs1_m[slot]];
            b       = model_rf[rs2_m[slot]];
            res     = model_pc + 32'd4; // link value for jal
            next_pc = model_pc + 32'd4;
            case (kind_m[slot])
                K_ADDI: res = a + imm_m[slot];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_LUI:  res = imm_m[slot];
                K_JAL:  next_pc = model_pc + imm_m[slot];
                default: begin
                    // beq taken on equal, bne on differ
                    if ((kind_m[slot] == K_BEQ) == (a == b)) begin
                        next_pc = model_pc + imm_m[slot];
                    end
                end
            endcase
            if (kind_m[slot] != K_BEQ && kind_m[slot] != K_BNE && rd_m[slot] != 5'd0) begin
                model_rf[rd_m[slot]] = res;
                addr  = rd_m[slot];
                data  = res;
                found = 1'b1;
            end
            model_pc = next_pc;
        end
        if (!found) begin
            $display("reference model ran 256 instructions without a register write");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    initial begin
        reg_addr_t exp_addr;
        word_t     exp_data;
        seed     = 63076;
        reset_i  = 1'b1;
        inst_i   = NOP_INST;
        cycles   = 0;
        matched  = 0;
        model_pc = 32'h0;
        model_rf = '{default: '0};
        build_program();
        while (matched < 400) begin
            @(negedge clk_i);
            cycles++;
            // 400 writes at up to 12 cycles each plus margin
            if (cycles > 5000) begin
                $display("timeout after %0d cycles, only %0d of 400 writes matched",
                         cycles - 1, matched);
                $display("RESULT: FAIL");
                $fatal(1);
            end
            if (cycles <= 4) begin
                assert (!wb_en_o) else begin
                    $display("FAIL t=%0t: wb_en_o high while reset holds the pipeline", $time);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
                reset_i = (cycles < 4); // released after 4 rising edges
            end else if (wb_en_o && wb_addr_o != 5'd0) begin
                next_model_write(exp_addr, exp_data);
                assert (wb_addr_o == exp_addr && wb_data_o == exp_data) else begin
                    $display("FAIL t=%0t: write x%0d = %08h, expected x%0d = %08h",
                             $time, wb_addr_o, wb_data_o, exp_addr, exp_data);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
                matched++;
            end
            inst_i = mem[inst_addr_o[7:2]]; // memory answers within the cycle
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
design/core_pkg.sv
design/pc_reg.sv
design/if_id.sv
design/id.sv
design/id_ex.sv
design/ex.sv
design/regs.sv
design/ctrl.sv
design/riscv_core.sv
testbench/tb_riscv_core.sv
